// File: pkt_replay.f
hdl/pkt_format_pkg.sv
hdl/pkt_ctrl_pkg.sv
hdl/wb_arbiter.sv
hdl/packet_cntl.sv
hdl/packet_sram.sv
hdl/replay_fifo.sv
hdl/pkt_replay_top.sv
testbench/pkt_replay_tb.sv

// File: testbench/pkt_replay_tb.sv
// Testbench for the packet replay buffer
// Directed tests against a model queue, LFSR packet values, watchdog
`timescale 1ns/1ps
`default_nettype none

module pkt_replay_tb import pkt_format_pkg::*, pkt_ctrl_pkg::*; ();

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED    = 32'h3de7_072b;
    localparam int          DRAIN_LIMIT  = 80;
    localparam int          HEAD_WAIT    = 4 * FIFO_DEPTH + 20;
    localparam int          QUIET_WAIT   = 30;
    localparam int          RESTART_WAIT = 10;

    // Rough length of each test in cycles
    localparam int BASIC_CYCLES     = 25 + DRAIN_LIMIT;
    localparam int PRIORITY_CYCLES  = 5 + DRAIN_LIMIT;
    localparam int BACKPRESS_CYCLES = 25 + HEAD_WAIT + DRAIN_LIMIT;
    localparam int STALL_CYCLES     = 16 + QUIET_WAIT + DRAIN_LIMIT;
    localparam int REPLAY_CYCLES    = 25 + QUIET_WAIT + 2 * RESTART_WAIT + DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES  = 2 * (RESET_CYCLES + BASIC_CYCLES + PRIORITY_CYCLES
                                         + BACKPRESS_CYCLES + STALL_CYCLES + REPLAY_CYCLES);

    logic                       clk;
    logic                       reset;
    pkt_msg_t                   dp_in;
    pkt_msg_t [NUM_EDGE_PE-1:0] edge_in;
    logic                       cntl_done;
    logic                       replay_iter;
    logic                       fifo_stall;
    logic                       pop;
    pkt_data_t                  out_packet;
    logic                       out_valid;

    logic [31:0] lfsr_state;
    pkt_data_t   expected_q[$];
    string       test_name;

    pkt_replay_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .dp_in       (dp_in),
        .edge_in     (edge_in),
        .cntl_done   (cntl_done),
        .replay_iter (replay_iter),
        .fifo_stall  (fifo_stall),
        .pop         (pop),
        .out_packet  (out_packet),
        .out_valid   (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic pkt_data_t random_packet();
        pkt_data_t p;
        for (int i = 0; i < PKT_WIDTH; i++) begin
            p[i] = lfsr_bit();
        end
        return p;
    endfunction

    function automatic pkt_msg_t random_msg();
        pkt_msg_t m;
        m.valid  = 1'b1;
        m.packet = random_packet();
        return m;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_packet(input string what, input pkt_data_t expected,
                                input pkt_data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: %s expected %h, actual %h",
                                     test_name, what, expected, actual));
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s: %s expected %b, actual %b",
                                     test_name, what, expected, actual));
        end
    endtask

    task automatic drive_inputs(input pkt_msg_t dp, input pkt_msg_t [NUM_EDGE_PE-1:0] edges);
        @(posedge clk);
        #1;
        dp_in   = dp;
        edge_in = edges;
    endtask

    // Back-to-back datapath packets that the model keeps only when they should come out
    task automatic send_dp_packets(input int count, input bit expect_out);
        pkt_msg_t msg;
        for (int i = 0; i < count; i++) begin
            msg = random_msg();
            if (expect_out) begin
                expected_q.push_back(msg.packet);
            end
            drive_inputs(msg, '0);
        end
        drive_inputs('0, '0);
    endtask

    task automatic set_pop(input logic level);
        @(posedge clk);
        #1;
        pop = level;
    endtask

    task automatic set_stall(input logic level);
        @(posedge clk);
        #1;
        fifo_stall = level;
    endtask

    task automatic pulse_done();
        @(posedge clk);
        #1;
        cntl_done = 1'b1;
        @(posedge clk);
        #1;
        cntl_done = 1'b0;
    endtask

    task automatic pulse_replay();
        @(posedge clk);
        #1;
        replay_iter = 1'b1;
        @(posedge clk);
        #1;
        replay_iter = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_flag("out_valid", 1'b0, out_valid);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                report_failure($sformatf("Test %s: %0d packets never came out",
                                         test_name, expected_q.size()));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Every popped packet must be the oldest expected one
    always @(posedge clk) begin
        if (!reset && out_valid && pop) begin
            if (expected_q.size() == 0) begin
                report_failure($sformatf("Test %s: packet %h came out, none was expected",
                                         test_name, out_packet));
            end else begin
                check_packet("out_packet", expected_q.pop_front(), out_packet);
            end
        end
    end

    task automatic basic_stream();
        test_name = "basic_stream";
        set_pop(1'b1);
        @(posedge clk);
        check_flag("out_valid after reset", 1'b0, out_valid);
        send_dp_packets(20, 1'b1);
        wait_drain();
    endtask

    task automatic priority_select();
        pkt_msg_t                   dp;
        pkt_msg_t [NUM_EDGE_PE-1:0] edges;
        test_name = "priority_select";
        // Datapath beats edge PEs
        dp       = random_msg();
        edges    = '0;
        edges[1] = random_msg();
        edges[3] = random_msg();
        expected_q.push_back(dp.packet);
        drive_inputs(dp, edges);
        // Highest index edge PE wins
        dp       = '0;
        edges    = '0;
        edges[0] = random_msg();
        edges[2] = random_msg();
        edges[3] = random_msg();
        expected_q.push_back(edges[3].packet);
        drive_inputs(dp, edges);
        edges    = '0;
        edges[0] = random_msg();
        edges[1] = random_msg();
        expected_q.push_back(edges[1].packet);
        drive_inputs(dp, edges);
        drive_inputs('0, '0);
        wait_drain();
    endtask

    task automatic backpressure();
        test_name = "backpressure";
        set_pop(1'b0);
        send_dp_packets(20, 1'b1);
        // FIFO fills and reads get dropped and rewound
        repeat (HEAD_WAIT) @(posedge clk);
        check_flag("out_valid while held", 1'b1, out_valid);
        check_packet("head while held", expected_q[0], out_packet);
        set_pop(1'b1);
        wait_drain();
    endtask

    task automatic stall_hold();
        test_name = "stall_hold";
        set_stall(1'b1);
        repeat (2) @(posedge clk);
        send_dp_packets(10, 1'b1);
        expect_quiet(QUIET_WAIT);
        set_stall(1'b0);
        wait_drain();
    endtask

    task automatic done_and_replay();
        test_name = "done_and_replay";
        pulse_done();
        // Parked controller stores nothing
        send_dp_packets(5, 1'b0);
        expect_quiet(QUIET_WAIT);
        pulse_replay();
        // Both addresses restart at line 0 so no stale line is read
        expect_quiet(RESTART_WAIT);
        send_dp_packets(10, 1'b1);
        wait_drain();
        // Nothing follows the fresh set
        expect_quiet(RESTART_WAIT);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        dp_in       = '0;
        edge_in     = '0;
        cntl_done   = 1'b0;
        replay_iter = 1'b0;
        fifo_stall  = 1'b0;
        pop         = 1'b0;
        lfsr_state  = LFSR_SEED;
        test_name   = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        basic_stream();
        priority_select();
        backpressure();
        stall_hold();
        done_and_replay();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Watchdog expired after %0d cycles in test %s, the run hung",
                                 WATCHDOG_CYCLES, test_name));
    end

endmodule

`default_nettype wire

// File: hdl/pkt_replay_top.sv
// Packet replay buffer top level
// Arbiter, controller, line SRAM and output FIFO in one pipeline
`timescale 1ns/1ps
`default_nettype none

module pkt_replay_top import pkt_format_pkg::*, pkt_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  pkt_msg_t                   dp_in,
    input  pkt_msg_t [NUM_EDGE_PE-1:0] edge_in,
    input  logic                       cntl_done,
    input  logic                       replay_iter,
    input  logic                       fifo_stall,
    input  logic                       pop,
    output pkt_data_t                  out_packet,
    output logic                       out_valid
);

    pkt_msg_t  wb_req;
    sram_req_t sram_req;
    pkt_data_t rdata;
    pkt_msg_t  fifo_push;
    logic      full;

    wb_arbiter u_wb_arbiter (
        .clk     (clk),
        .reset   (reset),
        .dp_in   (dp_in),
        .edge_in (edge_in),
        .wb_req  (wb_req)
    );

    packet_cntl u_packet_cntl (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .cntl_done   (cntl_done),
        .replay_iter (replay_iter),
        .fifo_stall  (fifo_stall),
        .full        (full),
        .rdata       (rdata),
        .sram_req    (sram_req),
        .fifo_push   (fifo_push)
    );

    packet_sram u_packet_sram (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (rdata)
    );

    replay_fifo u_replay_fifo (
        .clk        (clk),
        .reset      (reset),
        .fifo_push  (fifo_push),
        .pop        (pop),
        .full       (full),
        .out_valid  (out_valid),
        .out_packet (out_packet)
    );

endmodule

`default_nettype wire

// File: hdl/replay_fifo.sv
// Output replay FIFO
// Circular buffer with full flag, drops pushes when full, ignores pops when empty
`timescale 1ns/1ps
`default_nettype none

module replay_fifo import pkt_format_pkg::*, pkt_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pkt_msg_t  fifo_push,
    input  logic      pop,
    output logic      full,
    output logic      out_valid,
    output pkt_data_t out_packet
);

    pkt_data_t mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_count_t                   count;

    logic do_push;
    logic do_pop;

    assign full       = (count == fifo_count_t'(FIFO_DEPTH));
    assign out_valid  = (count != '0);
    assign out_packet = mem[rd_ptr];

    // Full wins even with a pop in the same cycle
    assign do_push = fifo_push.valid && !full;
    assign do_pop  = pop && out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage, pointers wrap on the power-of-two depth
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fifo_push.packet;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= fifo_count_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: hdl/packet_sram.sv
// Packet line SRAM
// Single port, write when wen is low, one-cycle synchronous read otherwise
`timescale 1ns/1ps
`default_nettype none

module packet_sram import pkt_format_pkg::*, pkt_ctrl_pkg::*; (
    input  logic      clk,
    input  sram_req_t sram_req,
    output pkt_data_t rdata
);

    pkt_data_t mem [MAX_PACKET_LINE];

    always_ff @(posedge clk) begin
        if (!sram_req.wen) begin
            mem[sram_req.addr] <= sram_req.data;
        end else begin
            // Read port, data held until the next read
            rdata <= mem[sram_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/packet_cntl.sv
// Packet controller
// FSM with write and read address generation on one SRAM port
// Pushes read data to the FIFO and rewinds the read address on a full FIFO
`timescale 1ns/1ps
`default_nettype none

module packet_cntl import pkt_format_pkg::*, pkt_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pkt_msg_t  wb_req,
    input  logic      cntl_done,
    input  logic      replay_iter,
    input  logic      fifo_stall,
    input  logic      full,
    input  pkt_data_t rdata,
    output sram_req_t sram_req,
    output pkt_msg_t  fifo_push
);

    cntl_state_t state;
    cntl_state_t state_nxt;

    line_addr_t wr_addr;
    line_addr_t rd_addr;
    // Address of the read whose data returns this cycle
    line_addr_t inflight_addr;
    logic       rd_pending;

    logic write_due;
    logic read_due;

    // Writes win the port, reads only in STREAM with unread lines left
    always_comb begin
        write_due = wb_req.valid && (state == STREAM || state == HOLD);
        read_due  = (state == STREAM)
                  && !write_due
                  && !fifo_stall
                  && !full
                  && !cntl_done
                  && (rd_addr != wr_addr);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                state_nxt = STREAM;
            end
            STREAM: begin
                if (cntl_done) begin
                    state_nxt = DONE;
                end else if (fifo_stall) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (cntl_done) begin
                    state_nxt = DONE;
                end else if (!fifo_stall) begin
                    state_nxt = STREAM;
                end
            end
            // Parked until replay or reset
            DONE: begin
                state_nxt = DONE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Port request, the address follows the read pointer when idle
    always_comb begin
        sram_req.wen  = !write_due;
        sram_req.addr = write_due ? wr_addr : rd_addr;
        sram_req.data = wb_req.packet;
    end

    // Read data arrives one cycle after the read
    always_comb begin
        fifo_push.valid  = rd_pending;
        fifo_push.packet = rdata;
    end

    always_ff @(posedge clk) begin
        if (reset || replay_iter) begin
            state      <= IDLE;
            wr_addr    <= '0;
            rd_addr    <= '0;
            rd_pending <= 1'b0;
        end else begin
            state      <= state_nxt;
            rd_pending <= read_due;
            if (write_due) begin
                wr_addr <= wr_addr + 1'b1;
            end
            // Push dropped by the FIFO, fetch that line again later
            if (rd_pending && full) begin
                rd_addr <= inflight_addr;
            end else if (read_due) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_due) begin
            inflight_addr <= rd_addr;
        end
    end

    // Every push traces back to a read cycle in STREAM with no write on the port
    a_push_after_read: assert property (@(posedge clk) disable iff (reset)
        fifo_push.valid |-> $past(sram_req.wen && state == STREAM));

    // Parked controller leaves the SRAM and the FIFO alone
    a_done_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == DONE) |-> (sram_req.wen && !fifo_push.valid));

endmodule

`default_nettype wire

// File: hdl/wb_arbiter.sv
// Writeback arbiter
// Registers one packet per cycle, datapath first, then the highest-index edge PE
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import pkt_format_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  pkt_msg_t                   dp_in,
    input  pkt_msg_t [NUM_EDGE_PE-1:0] edge_in,
    output pkt_msg_t                   wb_req
);

    pkt_msg_t  winner;
    logic      any_valid;
    logic      wb_valid;
    pkt_data_t wb_packet;

    always_comb begin
        winner    = dp_in;
        any_valid = dp_in.valid;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            any_valid = any_valid | edge_in[i].valid;
            // Later index overrides, datapath always wins
            if (!dp_in.valid && edge_in[i].valid) begin
                winner = edge_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= winner.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (winner.valid) begin
            wb_packet <= winner.packet;
        end
    end

    assign wb_req = '{valid: wb_valid, packet: wb_packet};

    // A forwarded packet always comes from some input one cycle earlier
    a_wb_from_input: assert property (@(posedge clk) disable iff (reset)
        wb_req.valid |-> $past(any_valid));

endmodule

`default_nettype wire

// File: hdl/pkt_ctrl_pkg.sv
// Controller and storage definitions
// SRAM and FIFO sizes, address and count types, SRAM request, FSM states
`default_nettype none

package pkt_ctrl_pkg;

    import pkt_format_pkg::*;

    // Line SRAM
    localparam int MAX_PACKET_LINE = 64;
    localparam int LINE_ADDR_W     = 6;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // Output FIFO, count needs one bit more than the pointers
    localparam int FIFO_DEPTH = 8;

    typedef logic [3:0] fifo_count_t;

    // Single-port SRAM request, wen low means write
    typedef struct packed {
        logic       wen;
        line_addr_t addr;
        pkt_data_t  data;
    } sram_req_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        HOLD,
        DONE
    } cntl_state_t;

endpackage

`default_nettype wire

// File: hdl/pkt_format_pkg.sv
// Packet format definitions
// Packet width, edge PE count and the valid-qualified packet message
`default_nettype none

package pkt_format_pkg;

    // Width of one packet, also the SRAM line width
    localparam int PKT_WIDTH = 32;

    // Edge processing elements feeding the writeback arbiter
    localparam int NUM_EDGE_PE = 4;

    // One packet
    typedef logic [PKT_WIDTH-1:0] pkt_data_t;

    // Packet with its valid strobe
    // Used on the datapath and edge PE inputs, the arbiter output and the FIFO push
    typedef struct packed {
        logic      valid;
        pkt_data_t packet;
    } pkt_msg_t;

endpackage

`default_nettype wire
